// File: source/dec_pkg.sv
// shared widths, opcode and exception constants
// alu operation encoding
// packed payloads between pipeline stages, writeback port and trace

package dec_pkg;

   // ********************
   // widths and constants
   // ********************
   localparam int XLEN   = 32;                  // data width
   localparam int PC_W   = 31;                  // pc[31:1], bit 0 implied zero
   localparam int NREGS  = 32;                  // general registers incl x0
   localparam int REG_AW = 5;                   // register address width

   localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate
   localparam logic [6:0] OPC_LUI    = 7'b0110111; // load upper immediate

   localparam logic [4:0] EXC_ILLEGAL = 5'd2;    // illegal instruction cause

   // ********************
   // alu operation
   // ********************
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_PASS                                   // op2 straight through, lui
   } alu_op_e;

   // ********************
   // stage payloads
   // ********************
   typedef struct packed {
      logic [31:0]     instr;                    // fetched instruction
      logic [PC_W-1:0] pc;                       // its pc
   } fetch_pkt_t;

   typedef struct packed {
      logic              valid;                  // one cycle per instruction
      logic              illegal;                // not a recognized encoding
      alu_op_e           alu_op;
      logic              rd_en;                  // writes a register
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   op1;                    // rs1 data or zero
      logic [XLEN-1:0]   op2;                    // rs2 data or immediate
      logic [31:0]       instr;
      logic [PC_W-1:0]   pc;
   } dec_pkt_t;

   typedef struct packed {
      logic              valid;
      logic              illegal;
      logic              rd_en;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   result;                 // alu output
      logic [31:0]       instr;
      logic [PC_W-1:0]   pc;
   } ex_pkt_t;

   typedef struct packed {
      logic              wen;                    // register file write enable
      logic [REG_AW-1:0] waddr;
      logic [XLEN-1:0]   wdata;
   } wb_pkt_t;

   typedef struct packed {
      logic            valid;                    // retired this cycle
      logic            exception;                // retired with exception
      logic [4:0]      ecause;
      logic [XLEN-1:0] tval;                     // faulting instruction
      logic [31:0]     insn;
      logic [PC_W-1:0] pc;
   } trace_pkt_t;

endpackage

// File: source/dec_decode.sv
// fetch req/ack handshake and decode stage register
// opcode and funct decode, I and U immediates
// register file read requests and operand select

module dec_decode (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       fetch_req,  // four-phase request
   input  dec_pkg::fetch_pkt_t        fetch,
   input  logic [dec_pkg::XLEN-1:0]   rs1_data,
   input  logic [dec_pkg::XLEN-1:0]   rs2_data,
   output logic                       fetch_ack,
   output logic [dec_pkg::REG_AW-1:0] rs1_addr,
   output logic [dec_pkg::REG_AW-1:0] rs2_addr,
   output logic                       rs1_en,
   output logic                       rs2_en,
   output dec_pkg::dec_pkt_t          dec
);

   logic                     accept;        // req high, ack still low
   logic                     valid_d;       // decode stage valid
   dec_pkg::fetch_pkt_t      fetch_d;       // decode stage instruction
   logic [6:0]               opcode;
   logic [2:0]               funct3;
   logic [6:0]               funct7;
   logic                     is_op;
   logic                     is_op_imm;
   logic                     is_lui;
   logic                     illegal;
   dec_pkg::alu_op_e         base_op;       // funct3 mapping shared by op and op-imm
   dec_pkg::alu_op_e         alu_op;
   logic [dec_pkg::XLEN-1:0] imm_i;
   logic [dec_pkg::XLEN-1:0] imm_u;

   // ********************
   // handshake and stage register
   // ********************
   assign accept = fetch_req & ~fetch_ack;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_ack <= 1'b0;
         valid_d   <= 1'b0;
         fetch_d   <= '0;
      end else begin
         valid_d <= accept;                  // single cycle valid
         if (accept) begin
            fetch_ack <= 1'b1;
            fetch_d   <= fetch;
         end else if (!fetch_req) begin
            fetch_ack <= 1'b0;               // req dropped, release ack
         end
      end
   end

   // ********************
   // field decode
   // ********************
   assign opcode    = fetch_d.instr[6:0];
   assign funct3    = fetch_d.instr[14:12];
   assign funct7    = fetch_d.instr[31:25];
   assign is_op     = (opcode == dec_pkg::OPC_OP);
   assign is_op_imm = (opcode == dec_pkg::OPC_OP_IMM);
   assign is_lui    = (opcode == dec_pkg::OPC_LUI);

   always_comb begin
      case (funct3)
         3'b000:  base_op = dec_pkg::ALU_ADD;
         3'b001:  base_op = dec_pkg::ALU_SLL;
         3'b010:  base_op = dec_pkg::ALU_SLT;
         3'b011:  base_op = dec_pkg::ALU_SLTU;
         3'b100:  base_op = dec_pkg::ALU_XOR;
         3'b101:  base_op = dec_pkg::ALU_SRL;
         3'b110:  base_op = dec_pkg::ALU_OR;
         default: base_op = dec_pkg::ALU_AND;
      endcase
   end

   always_comb begin
      alu_op  = base_op;
      illegal = 1'b1;                        // until an encoding matches
      if (is_op) begin
         if (funct7 == 7'b0000000) begin
            illegal = 1'b0;
         end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
            alu_op  = dec_pkg::ALU_SUB;
            illegal = 1'b0;
         end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
            alu_op  = dec_pkg::ALU_SRA;
            illegal = 1'b0;
         end
      end else if (is_op_imm) begin
         if (funct3 != 3'b001 && funct3 != 3'b101) begin
            illegal = 1'b0;                  // no funct7 field, plain immediate
         end else if (funct7 == 7'b0000000) begin
            illegal = 1'b0;                  // slli, srli
         end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
            alu_op  = dec_pkg::ALU_SRA;      // srai
            illegal = 1'b0;
         end
      end else if (is_lui) begin
         alu_op  = dec_pkg::ALU_PASS;
         illegal = 1'b0;
      end
   end

   // ********************
   // immediates and operands
   // ********************
   assign imm_i = {{20{fetch_d.instr[31]}}, fetch_d.instr[31:20]}; // sign extended
   assign imm_u = {fetch_d.instr[31:12], 12'b0};

   assign rs1_addr = fetch_d.instr[19:15];
   assign rs2_addr = fetch_d.instr[24:20];
   assign rs1_en   = valid_d & (is_op | is_op_imm);  // lui reads zero
   assign rs2_en   = valid_d & is_op;

   always_comb begin
      dec.valid   = valid_d;
      dec.illegal = illegal;
      dec.alu_op  = alu_op;
      dec.rd      = fetch_d.instr[11:7];
      dec.rd_en   = ~illegal & (fetch_d.instr[11:7] != '0); // x0 never written
      dec.op1     = rs1_data;
      dec.op2     = is_op ? rs2_data : (is_lui ? imm_u : imm_i);
      dec.instr   = fetch_d.instr;
      dec.pc      = fetch_d.pc;
   end

endmodule

// File: source/dec_gpr.sv
// general register file, 31 writable entries plus x0
// two read ports with write-through, one write port

module dec_gpr (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [dec_pkg::REG_AW-1:0] rs1_addr,
   input  logic [dec_pkg::REG_AW-1:0] rs2_addr,
   input  logic                       rs1_en,
   input  logic                       rs2_en,
   input  dec_pkg::wb_pkt_t           wb,         // write port from writeback
   output logic [dec_pkg::XLEN-1:0]   rs1_data,
   output logic [dec_pkg::XLEN-1:0]   rs2_data
);

   logic [dec_pkg::XLEN-1:0] regs [dec_pkg::NREGS]; // entry 0 stays zero

   // read port, write data wins on address match
   function automatic logic [dec_pkg::XLEN-1:0] rd_port(
      input logic                       en,
      input logic [dec_pkg::REG_AW-1:0] addr
   );
      logic [dec_pkg::XLEN-1:0] data;
      data = '0;                                  // disabled or x0
      if (en && addr != '0) begin
         if (wb.wen && wb.waddr == addr) data = wb.wdata;
         else                            data = regs[addr];
      end
      return data;
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < dec_pkg::NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wen && wb.waddr != '0) begin
         regs[wb.waddr] <= wb.wdata;              // x0 ignores writes
      end
   end

   // follows wb and regs as well as the read addresses
   always_comb begin
      rs1_data = rd_port(rs1_en, rs1_addr);
      rs2_data = rd_port(rs2_en, rs2_addr);
   end

endmodule

// File: source/dec_execute.sv
// execute stage register
// integer alu for op, op-imm and lui
// execute-to-result payload

module dec_execute (
   input  logic                clk,
   input  logic                rst_n,
   input  dec_pkg::dec_pkt_t   dec,              // from decode
   output dec_pkg::ex_pkt_t    ex                // to result
);

   dec_pkg::dec_pkt_t        dec_e1;             // stage register
   logic [4:0]               shamt;
   logic [dec_pkg::XLEN-1:0] result;

   // ********************
   // stage register
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_e1 <= '0;
      end else begin
         dec_e1 <= dec;                          // no stall, always advance
      end
   end

   // ********************
   // alu
   // ********************
   assign shamt = dec_e1.op2[4:0];              // low 5 bits only

   always_comb begin
      case (dec_e1.alu_op)
         dec_pkg::ALU_ADD:  result = dec_e1.op1 + dec_e1.op2;
         dec_pkg::ALU_SUB:  result = dec_e1.op1 - dec_e1.op2;
         dec_pkg::ALU_SLL:  result = dec_e1.op1 << shamt;
         dec_pkg::ALU_SLT: begin
            result = {31'b0, $signed(dec_e1.op1) < $signed(dec_e1.op2)};
         end
         dec_pkg::ALU_SLTU: begin
            result = {31'b0, dec_e1.op1 < dec_e1.op2};
         end
         dec_pkg::ALU_XOR:  result = dec_e1.op1 ^ dec_e1.op2;
         dec_pkg::ALU_SRL:  result = dec_e1.op1 >> shamt;
         dec_pkg::ALU_SRA:  result = $unsigned($signed(dec_e1.op1) >>> shamt);
         dec_pkg::ALU_OR:   result = dec_e1.op1 | dec_e1.op2;
         dec_pkg::ALU_AND:  result = dec_e1.op1 & dec_e1.op2;
         default:           result = dec_e1.op2;    // pass, lui
      endcase
   end

   // ********************
   // payload out
   // ********************
   always_comb begin
      ex.valid   = dec_e1.valid;
      ex.illegal = dec_e1.illegal;
      ex.rd_en   = dec_e1.rd_en;
      ex.rd      = dec_e1.rd;
      ex.result  = result;
      ex.instr   = dec_e1.instr;
      ex.pc      = dec_e1.pc;
   end

endmodule

// File: source/dec_result.sv
// writeback stage register and register file write control
// retirement trace registers, one cycle after writeback

module dec_result (
   input  logic                clk,
   input  logic                rst_n,
   input  dec_pkg::ex_pkt_t    ex,               // from execute
   output dec_pkg::wb_pkt_t    wb,               // register file write
   output dec_pkg::trace_pkt_t trace             // retirement trace
);

   dec_pkg::ex_pkt_t           ex_wb;            // writeback stage
   logic                       valid_wb1;
   logic                       exc_valid_wb1;    // illegal retired
   logic [4:0]                 exc_cause_wb1;
   logic [dec_pkg::XLEN-1:0]   mtval_wb1;
   logic [31:0]                inst_wb1;
   logic [dec_pkg::PC_W-1:0]   pc_wb1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_wb <= '0;
      end else begin
         ex_wb <= ex;
      end
   end

   // write only legal instructions with a real rd
   assign wb.wen   = ex_wb.valid & ex_wb.rd_en & ~ex_wb.illegal;
   assign wb.waddr = ex_wb.rd;
   assign wb.wdata = ex_wb.result;

   // ********************
   // trace, wb1 stage
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_wb1     <= 1'b0;
         exc_valid_wb1 <= 1'b0;
         exc_cause_wb1 <= '0;
         mtval_wb1     <= '0;
         inst_wb1      <= '0;
         pc_wb1        <= '0;
      end else begin
         valid_wb1     <= ex_wb.valid;
         exc_valid_wb1 <= ex_wb.valid & ex_wb.illegal;
         exc_cause_wb1 <= ex_wb.illegal ? dec_pkg::EXC_ILLEGAL : 5'd0;
         mtval_wb1     <= ex_wb.illegal ? ex_wb.instr : '0; // faulting insn
         inst_wb1      <= ex_wb.instr;
         pc_wb1        <= ex_wb.pc;
      end
   end

   assign trace.valid     = valid_wb1;
   assign trace.exception = exc_valid_wb1;
   assign trace.ecause    = exc_cause_wb1;
   assign trace.tval      = mtval_wb1;
   assign trace.insn      = inst_wb1;
   assign trace.pc        = pc_wb1;

endmodule

// File: source/dec_top.sv
// decode pipeline top level
// decode, register file, execute and result stages

module dec_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                fetch_req,
   input  dec_pkg::fetch_pkt_t fetch,
   output logic                fetch_ack,
   output dec_pkg::wb_pkt_t    wb,
   output dec_pkg::trace_pkt_t trace
);

   logic [dec_pkg::REG_AW-1:0] rs1_addr;
   logic [dec_pkg::REG_AW-1:0] rs2_addr;
   logic                       rs1_en;
   logic                       rs2_en;
   logic [dec_pkg::XLEN-1:0]   rs1_data;
   logic [dec_pkg::XLEN-1:0]   rs2_data;
   dec_pkg::dec_pkt_t          dec;              // decode to execute
   dec_pkg::ex_pkt_t           ex;               // execute to result

   dec_decode i_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .fetch_req (fetch_req),
      .fetch     (fetch),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .fetch_ack (fetch_ack),
      .rs1_addr  (rs1_addr),
      .rs2_addr  (rs2_addr),
      .rs1_en    (rs1_en),
      .rs2_en    (rs2_en),
      .dec       (dec)
   );

   dec_gpr i_gpr (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_en   (rs1_en),
      .rs2_en   (rs2_en),
      .wb       (wb),                            // writeback loops back here
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   dec_execute i_execute (
      .clk   (clk),
      .rst_n (rst_n),
      .dec   (dec),
      .ex    (ex)
   );

   dec_result i_result (
      .clk   (clk),
      .rst_n (rst_n),
      .ex    (ex),
      .wb    (wb),
      .trace (trace)
   );

endmodule

// File: verif/tb_clock.sv
// free running testbench clock
// 4 ns period, starts low

module tb_clock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_NS = 2;                   // half of the 4 ns period

   initial clk = 1'b0;

   always #HALF_NS clk = ~clk;

endmodule

// File: verif/dec_assertions.sv
// checker bound to the decode pipeline top level
// shadow register file, queue of accepted fetch packets
// concurrent assertions for reset, handshake, writeback and trace

module dec_assertions (
   input logic                clk,
   input logic                rst_n,
   input logic                fetch_req,
   input dec_pkg::fetch_pkt_t fetch,
   input logic                fetch_ack,
   input dec_pkg::wb_pkt_t    wb,
   input dec_pkg::trace_pkt_t trace
);
   timeunit 1ns;
   timeprecision 100ps;

   int                  n_control = 0;           // reset, handshake, latency
   int                  n_value   = 0;           // writeback port
   int                  n_trace   = 0;           // trace packet contents

   dec_pkg::fetch_pkt_t pend [$];                // accepted, not yet retired
   dec_pkg::fetch_pkt_t head;                    // oldest in flight
   logic [31:0]         shadow [32];
   logic                ack_q;
   logic                req_q;
   logic                ack_rise;
   logic [2:0]          stage_q;                 // ack rise delayed, execute..trace
   logic                out_of_reset;
   logic                exp_legal;
   logic                exp_wen;
   logic [31:0]         exp_data;
   logic [5:0]          exp_exc;                 // exception bit and cause

   // legal rv32i op, op-imm and lui encodings
   function automatic logic legal(input logic [31:0] ins);
      logic [6:0] f7;
      logic [2:0] f3;
      f7 = ins[31:25];
      f3 = ins[14:12];
      case (ins[6:0])
         dec_pkg::OPC_OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
         dec_pkg::OPC_OP_IMM: return (f3 == 3'd1) ? (f7 == 7'h00)
                                                 : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
         dec_pkg::OPC_LUI:    return 1'b1;
         default:             return 1'b0;
      endcase
   endfunction

   // rv32i result from rs1 value and rs2 value
   function automatic logic [31:0] rv32i_value(input logic [31:0] ins,
                                               input logic [31:0] a,
                                               input logic [31:0] b_reg);
      logic [31:0] b;
      logic        is_op;
      is_op = (ins[6:0] == dec_pkg::OPC_OP);
      b     = is_op ? b_reg : {{20{ins[31]}}, ins[31:20]};   // rs2 or imm_i
      if (ins[6:0] == dec_pkg::OPC_LUI) return {ins[31:12], 12'h000};
      case (ins[14:12])
         3'd0:    return (is_op && ins[30]) ? a - b : a + b;  // addi never subtracts
         3'd1:    return a << b[4:0];
         3'd2:    return {31'd0, $signed(a) < $signed(b)};
         3'd3:    return {31'd0, a < b};
         3'd4:    return a ^ b;
         3'd5:    return ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   // ********************
   // reference model
   // ********************
   assign ack_rise = fetch_ack & ~ack_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend.delete();
         head         <= '0;
         ack_q        <= 1'b0;
         req_q        <= 1'b0;
         stage_q      <= '0;
         out_of_reset <= 1'b0;
         for (int i = 0; i < 32; i++) begin
            shadow[i] <= '0;
         end
      end else begin
         if (fetch_req && !fetch_ack) pend.push_back(fetch);   // accept edge
         if (stage_q[2]) void'(pend.pop_front());              // retired
         if (pend.size() != 0) head <= pend[0];
         else                  head <= '0;
         if (wb.wen && wb.waddr != 5'd0) shadow[wb.waddr] <= wb.wdata;
         ack_q        <= fetch_ack;
         req_q        <= fetch_req;
         stage_q      <= {stage_q[1:0], ack_rise};
         out_of_reset <= 1'b1;
      end
   end

   always_comb begin
      exp_legal = legal(head.instr);
      exp_wen   = exp_legal && head.instr[11:7] != 5'd0;        // x0 never written
      exp_data  = rv32i_value(head.instr, shadow[head.instr[19:15]],
                              shadow[head.instr[24:20]]);
      exp_exc   = exp_legal ? 6'h00 : {1'b1, dec_pkg::EXC_ILLEGAL};
   end

   // ********************
   // reset and handshake
   // ********************
   a_reset_idle: assert property (@(posedge clk)
      !out_of_reset |-> !fetch_ack && !wb.wen && !trace.valid)
      else begin
         n_control++;
         $error("CHECK FAILED fetch_ack/wb.wen/trace.valid got %h/%h/%h expected 0/0/0",
                $sampled(fetch_ack), $sampled(wb.wen), $sampled(trace.valid));
      end

   a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) ack_rise |-> req_q)
      else begin n_control++; $error("fetch_ack rose without a pending fetch_req"); end

   a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
      ack_q && req_q |-> fetch_ack)
      else begin n_control++; $error("fetch_ack dropped while fetch_req was still high"); end

   a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
      ack_q && !req_q |-> !fetch_ack)
      else begin n_control++; $error("fetch_ack stayed high after fetch_req fell"); end

   a_trace_latency: assert property (@(posedge clk) disable iff (!rst_n)
      trace.valid == stage_q[2])
      else begin
         n_control++;
         $error("CHECK FAILED trace.valid got %h expected %h",
                $sampled(trace.valid), $sampled(stage_q[2]));
      end

   // ********************
   // writeback
   // ********************
   a_wen: assert property (@(posedge clk) disable iff (!rst_n)
      wb.wen == (stage_q[1] && exp_wen))
      else begin
         n_value++;
         $error("CHECK FAILED wb.wen got %h expected %h",
                $sampled(wb.wen), $sampled(stage_q[1] && exp_wen));
      end

   a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
      wb.wen |-> wb.waddr == head.instr[11:7])
      else begin
         n_value++;
         $error("CHECK FAILED wb.waddr got %h expected %h",
                $sampled(wb.waddr), $sampled(head.instr[11:7]));
      end

   a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
      wb.wen |-> wb.wdata == exp_data)
      else begin
         n_value++;
         $error("CHECK FAILED wb.wdata got %h expected %h",
                $sampled(wb.wdata), $sampled(exp_data));
      end

   // ********************
   // trace
   // ********************
   a_trace_insn: assert property (@(posedge clk) disable iff (!rst_n)
      trace.valid |-> trace.insn == head.instr && trace.pc == head.pc)
      else begin
         n_trace++;
         $error("CHECK FAILED trace.insn/pc got %h/%h expected %h/%h",
                $sampled(trace.insn), $sampled(trace.pc),
                $sampled(head.instr), $sampled(head.pc));
      end

   a_trace_exc: assert property (@(posedge clk) disable iff (!rst_n)
      trace.valid |-> {trace.exception, trace.ecause} == exp_exc)
      else begin
         n_trace++;
         $error("CHECK FAILED trace.exception/ecause got %h expected %h",
                $sampled({trace.exception, trace.ecause}), $sampled(exp_exc));
      end

   a_trace_tval: assert property (@(posedge clk) disable iff (!rst_n)
      trace.valid |-> trace.tval == (exp_legal ? 32'd0 : head.instr))
      else begin
         n_trace++;
         $error("CHECK FAILED trace.tval got %h expected %h", $sampled(trace.tval),
                $sampled(exp_legal ? 32'd0 : head.instr));
      end

endmodule

// File: verif/tb_top.sv
// testbench top, dut instance, reset and fetch stimulus
// register setup, random op/op-imm/lui/illegal stream, dependent pairs
// watchdog and closing error summary

module tb_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_LOOPS   = 150;                 // random draws
   localparam int N_MAX     = 7 + 2 * N_LOOPS;     // setup plus pairs counted twice
   localparam int WD_CYCLES = N_MAX * 8 + 50;

   logic                     clk;
   logic                     rst_n;
   logic                     fetch_req;
   dec_pkg::fetch_pkt_t      fetch;
   logic                     fetch_ack;
   dec_pkg::wb_pkt_t         wb;
   dec_pkg::trace_pkt_t      trace;
   int                       seed = 63;
   logic [dec_pkg::PC_W-1:0] pc;                   // halfword index, bit 0 implied
   int                       errors;

   tb_clock i_clock (.clk(clk));

   dec_top i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .fetch_req (fetch_req),
      .fetch     (fetch),
      .fetch_ack (fetch_ack),
      .wb        (wb),
      .trace     (trace)
   );

   bind dec_top dec_assertions i_assert (
      .clk(clk), .rst_n(rst_n), .fetch_req(fetch_req), .fetch(fetch),
      .fetch_ack(fetch_ack), .wb(wb), .trace(trace)
   );

   // ********************
   // encoders
   // ********************
   function automatic logic [31:0] build_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, dec_pkg::OPC_OP};
   endfunction

   function automatic logic [31:0] build_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, dec_pkg::OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] build_u(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, dec_pkg::OPC_LUI};
   endfunction

   // ********************
   // random instructions
   // ********************
   task automatic draw_op(input logic [4:0] rs1, output logic [31:0] ins);
      logic [2:0] f3;
      logic       alt;
      f3  = 3'($random(seed));
      alt = 1'($random(seed)) && (f3 == 3'd0 || f3 == 3'd5);   // sub or sra
      ins = build_r({1'b0, alt, 5'd0}, 5'($random(seed)), rs1, f3, 5'($random(seed)));
   endtask

   task automatic draw_illegal(output logic [31:0] ins);
      case (2'($random(seed)))
         2'd0: ins = {25'($random(seed)), 7'b0000011};           // load opcode
         2'd1: ins = build_r(7'h01, 5'($random(seed)), 5'($random(seed)),
                             3'($random(seed)), 5'($random(seed)));   // m extension
         2'd2: ins = build_r(7'h20, 5'($random(seed)), 5'($random(seed)), 3'd1, 5'd3);
         default: ins = build_i({7'h20, 5'($random(seed))}, 5'd2, 3'd1, 5'd4); // bad slli
      endcase
   endtask

   task automatic draw_instr(output logic [31:0] ins);
      logic [2:0]  f3;
      logic [11:0] imm;
      case (3'($random(seed)))
         3'd0:             draw_illegal(ins);           // about one in eight
         3'd1, 3'd2, 3'd3: draw_op(5'($random(seed)), ins);
         3'd4, 3'd5, 3'd6: begin
            f3  = 3'($random(seed));
            imm = 12'($random(seed));
            if (f3 == 3'd1) imm[11:5] = 7'h00;                    // slli
            if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'd0};    // srli or srai
            ins = build_i(imm, 5'($random(seed)), f3, 5'($random(seed)));
         end
         default:          ins = build_u(20'($random(seed)), 5'($random(seed)));
      endcase
   endtask

   // one four-phase transfer, inputs change on falling edges
   task automatic send(input logic [31:0] ins, input int gap, input int hold);
      repeat (gap) @(negedge clk);
      fetch.instr = ins;
      fetch.pc    = pc;
      fetch_req   = 1'b1;
      do @(negedge clk); while (!fetch_ack);            // captured at rising edge
      repeat (hold) @(negedge clk);                     // slow requester keeps req up
      fetch_req = 1'b0;
      do @(negedge clk); while (fetch_ack);             // wait for release
      pc += 31'd2;                                      // next word
   endtask

   // ********************
   // stimulus
   // ********************
   initial begin
      logic [31:0] first;
      logic [31:0] second;
      int          wait_cycles;
      int          hold_cycles;
      rst_n     = 1'b0;
      fetch_req = 1'b0;
      fetch     = '0;
      pc        = 31'h100;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      for (int r = 1; r < 8; r++) begin
         send(build_i(12'(r * 'h2a7), 5'd0, 3'd0, 5'(r)), 0, 0);  // addi xr, x0, known
      end
      for (int i = 0; i < N_LOOPS; i++) begin
         if (3'($random(seed)) == 3'd0) begin
            draw_op(5'($random(seed)), first);
            if (first[11:7] == 5'd0) first[11:7] = 5'd1;      // needs a real rd
            draw_op(first[11:7], second);                     // reads it right away
            send(first, 0, 0);
            send(second, 0, 0);
         end else begin
            draw_instr(first);
            wait_cycles = $unsigned($random(seed)) % 4;
            hold_cycles = $unsigned($random(seed)) % 3;
            send(first, wait_cycles, hold_cycles);
         end
      end
      repeat (6) @(negedge clk);                            // trace lags ack by 3
      errors = i_dut.i_assert.n_control + i_dut.i_assert.n_value + i_dut.i_assert.n_trace;
      $display("errors: control %0d, writeback %0d, trace %0d, total %0d",
               i_dut.i_assert.n_control, i_dut.i_assert.n_value,
               i_dut.i_assert.n_trace, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // hang guard
   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, fetch handshake or pipeline hung",
               WD_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: sim.f
source/dec_pkg.sv
source/dec_decode.sv
source/dec_gpr.sv
source/dec_execute.sv
source/dec_result.sv
source/dec_top.sv
verif/tb_clock.sv
verif/dec_assertions.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# compile and run the decode pipeline testbench with verilator

cd "$(dirname "$0")" || exit 1

obj=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_top -Mdir "$obj" -o tb_top_sim -f sim.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

"./$obj/tb_top_sim" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST OK$" "$log"; then
   exit 0
fi
echo "pass message not found in $log"
exit 1
